// ==== bench/tcdm_vectors.txt ====
# test step port wen addr be wdata expected
# addr, be, wdata and expected in hex; expected is checked for reads only
2 0 0 1 04 f 11111111 00000000
2 0 1 1 09 f 22222222 00000000
2 0 2 1 0e f 33333333 00000000
2 0 3 1 13 f 44444444 00000000
2 1 0 0 04 0 00000000 11111111
2 1 1 0 09 0 00000000 22222222
2 1 2 0 0e 0 00000000 33333333
2 1 3 0 13 0 00000000 44444444
3 2 1 1 04 3 aaaabbbb 00000000
3 2 2 1 09 c ccccdddd 00000000
3 3 3 0 04 0 00000000 1111bbbb
3 3 0 0 09 0 00000000 cccc2222
3 4 0 1 0e 5 5a5a5a5a 00000000
3 5 1 0 0e 0 00000000 335a335a
4 6 0 0 13 0 00000000 44444444
4 6 1 0 0e 0 00000000 335a335a
4 6 2 0 09 0 00000000 cccc2222
4 6 3 0 04 0 00000000 1111bbbb
5 7 0 1 01 f 0a0a0a0a 00000000
5 7 1 0 09 0 00000000 cccc2222
5 7 2 1 05 f 0b0b0b0b 00000000
5 7 3 0 09 0 00000000 cccc2222
5 8 0 0 05 0 00000000 0b0b0b0b
5 8 1 0 01 0 00000000 0a0a0a0a
5 8 2 0 09 0 00000000 cccc2222
5 8 3 0 01 0 00000000 0a0a0a0a

// ==== filelist.f ====
logic/tcdm_pkg.sv
logic/tcdm_rr_arbiter.sv
logic/tcdm_req_xbar.sv
logic/tcdm_bank.sv
logic/tcdm_resp_xbar.sv
logic/tcdm_group.sv
bench/tb_tcdm_group.sv

// ==== bench/tb_tcdm_group.sv ====
// --------------------
// Testbench for the local memory group: vector replay,
// random traffic and a reference memory model
// --------------------
module tb_tcdm_group;

  import tcdm_pkg::*;

  localparam int    Period  = 40;
  localparam int    MaxVecs = 64;
  localparam int    NumRand = 200;
  localparam int    Margin  = 100 * Period;
  localparam string VecFile = "bench/tcdm_vectors.txt";

  logic                      clk;
  logic                      rst_n;
  logic       [NumPorts-1:0] req_valid;
  logic       [NumPorts-1:0] req_wen;
  tcdm_addr_u [NumPorts-1:0] req_addr;
  strb_t      [NumPorts-1:0] req_be;
  data_t      [NumPorts-1:0] req_wdata;
  logic       [NumPorts-1:0] req_ready;
  logic       [NumPorts-1:0] resp_valid;
  data_t      [NumPorts-1:0] resp_rdata;

  // Reference memory, with a mask of bytes written so far
  data_t model_mem   [2**AddrWidth];
  strb_t model_known [2**AddrWidth];

  // Expected responses, ring of slots indexed by edge count
  logic  exp_valid [NumPorts][4];
  data_t exp_data  [NumPorts][4];

  // Vector file contents
  int    vec_test  [MaxVecs];
  int    vec_step  [MaxVecs];
  int    vec_port  [MaxVecs];
  int    vec_wen   [MaxVecs];
  int    vec_addr  [MaxVecs];
  int    vec_be    [MaxVecs];
  data_t vec_wdata [MaxVecs];
  data_t vec_exp   [MaxVecs];
  int    nvec;

  logic  [NumPorts-1:0] drive_chk;
  data_t [NumPorts-1:0] drive_exp;
  logic  [NumPorts-1:0] accepted;
  int                   edge_cnt;
  int                   err_cnt;
  int                   chk_cnt;
  int                   tests_run;
  int                   tests_failed;
  int                   test_err_base;
  logic [31:0]          rng;

  tcdm_group DUT (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .req_valid_i (req_valid ),
    .req_wen_i   (req_wen   ),
    .req_addr_i  (req_addr  ),
    .req_be_i    (req_be    ),
    .req_wdata_i (req_wdata ),
    .req_ready_o (req_ready ),
    .resp_valid_o(resp_valid),
    .resp_rdata_o(resp_rdata)
  );

  initial clk = 1'b0;
  always #(Period / 2) clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset";
      2:       return "write then read";
      3:       return "byte enables";
      4:       return "parallel banks";
      5:       return "conflict fairness";
      default: return "random traffic";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    err_cnt++;
  endtask

  task automatic apply_write(input int a, input strb_t be, input data_t d);
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        model_mem[a][8*i +: 8] = d[8*i +: 8];
        model_known[a][i]      = 1'b1;
      end
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen(VecFile, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VecFile);
      err_cnt++;
    end else begin
      while (!$feof(fd) && nvec < MaxVecs) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %d %d %h %h %h %h", vec_test[nvec], vec_step[nvec],
                      vec_port[nvec], vec_wen[nvec], vec_addr[nvec], vec_be[nvec],
                      vec_wdata[nvec], vec_exp[nvec]);
          if (n == 8) begin
            nvec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One clock: check responses, record acceptances, return at the falling edge
  task automatic run_cycle();
    int slot;
    int nxt;
    int a;
    @(posedge clk);
    edge_cnt++;
    slot     = edge_cnt % 4;
    nxt      = (edge_cnt + 1) % 4;
    accepted = req_valid & req_ready;
    for (int p = 0; p < NumPorts; p++) begin
      chk_cnt++;
      if (resp_valid[p] !== exp_valid[p][slot]) begin
        report_mismatch($sformatf("resp_valid_o[%0d]", p), exp_valid[p][slot], resp_valid[p]);
      end else if (exp_valid[p][slot] && resp_rdata[p] !== exp_data[p][slot]) begin
        report_mismatch($sformatf("resp_rdata_o[%0d]", p), exp_data[p][slot], resp_rdata[p]);
      end
      exp_valid[p][slot] = 1'b0;
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (accepted[p]) begin
        a = req_addr[p].flat;
        if (req_wen[p]) begin
          apply_write(a, req_be[p], req_wdata[p]);
        end else begin
          exp_valid[p][nxt] = 1'b1;
          exp_data[p][nxt]  = model_mem[a];
          if (drive_chk[p] && model_mem[a] !== drive_exp[p]) begin
            $display("Error at %0t: vector expects %h at word %0d but the model holds %h",
                     $time, drive_exp[p], a, model_mem[a]);
            err_cnt++;
          end
        end
      end
    end
    @(negedge clk);
  endtask

  // Requests of one step go out together and are held until accepted
  task automatic run_step(input int first, input int last);
    int                  cycles;
    int                  p;
    logic [NumPorts-1:0] held;
    int                  wins [NumPorts];
    for (int i = first; i <= last; i++) begin
      p                = vec_port[i];
      req_valid[p]     = 1'b1;
      req_wen[p]       = (vec_wen[i] != 0);
      req_addr[p].flat = AddrWidth'(vec_addr[i]);
      req_be[p]        = strb_t'(vec_be[i]);
      req_wdata[p]     = vec_wdata[i];
      drive_exp[p]     = vec_exp[i];
      drive_chk[p]     = (vec_wen[i] != 0) ? 1'b0 : 1'b1;
    end
    cycles = 0;
    if (vec_test[first] == 5) begin
      // Ports keep requesting, so only a fair arbiter grants each of them once
      held = req_valid;
      for (int q = 0; q < NumPorts; q++) begin
        wins[q] = 0;
      end
      repeat (last - first + 1) begin
        run_cycle();
        for (int q = 0; q < NumPorts; q++) begin
          if (accepted[q]) begin
            wins[q]++;
          end
        end
      end
      req_valid = '0;
      for (int q = 0; q < NumPorts; q++) begin
        if (held[q] && wins[q] != 1) begin
          $display("Port %0d was granted %0d times in %0d conflicting grants",
                   q, wins[q], last - first + 1);
          err_cnt++;
        end
      end
    end else begin
      while (req_valid != '0) begin
        run_cycle();
        cycles++;
        req_valid = req_valid & ~accepted;
      end
      if (vec_test[first] == 4 && cycles != 1) begin
        $display("Requests to distinct banks took %0d cycles instead of one", cycles);
        err_cnt++;
      end
    end
    drive_chk = '0;
  endtask

  task automatic run_random();
    int          issued;
    logic [31:0] r;
    int          a;
    issued = 0;
    while (issued < NumRand || req_valid != '0) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (!req_valid[p] && issued < NumRand) begin
          rng = xorshift32(rng);
          r   = rng;
          if (r[0]) begin
            a                = r[AddrWidth+1:2];
            req_valid[p]     = 1'b1;
            req_wen[p]       = r[1];
            req_addr[p].flat = AddrWidth'(a);
            req_be[p]        = r[AddrWidth+2 +: StrbWidth];
            rng              = xorshift32(rng);
            req_wdata[p]     = rng;
            // Unwritten words are filled before they are read
            if (!r[1] && model_known[a] != '1) begin
              req_wen[p] = 1'b1;
              req_be[p]  = '1;
            end
            issued++;
          end
        end
      end
      run_cycle();
      req_valid = req_valid & ~accepted;
    end
  endtask

  task automatic open_test();
    tests_run++;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test(input int id);
    repeat (2) run_cycle();
    if (err_cnt != test_err_base) begin
      tests_failed++;
      $display("Test %0d (%s): failed, %0d errors", id, test_name(id), err_cnt - test_err_base);
    end else begin
      $display("Test %0d (%s): ok", id, test_name(id));
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int first;
    int last;
    int cur_test;
    rst_n     = 1'b0;
    req_valid = '0;
    req_wen   = '0;
    req_addr  = '0;
    req_be    = '0;
    req_wdata = '0;
    drive_chk = '0;
    drive_exp = '0;
    rng       = 32'ha0b;
    for (int a = 0; a < 2**AddrWidth; a++) begin
      model_known[a] = '0;
    end
    for (int p = 0; p < NumPorts; p++) begin
      for (int s = 0; s < 4; s++) begin
        exp_valid[p][s] = 1'b0;
      end
    end
    load_vectors();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    open_test();
    repeat (3) begin
      chk_cnt++;
      if (req_ready !== '0) begin
        report_mismatch("req_ready_o", '0, req_ready);
      end
      run_cycle();
    end
    finish_test(1);

    cur_test = 0;
    first    = 0;
    while (first < nvec) begin
      last = first;
      while (last + 1 < nvec && vec_step[last+1] == vec_step[first]) begin
        last++;
      end
      if (vec_test[first] != cur_test) begin
        if (cur_test != 0) begin
          finish_test(cur_test);
        end
        cur_test = vec_test[first];
        open_test();
      end
      run_step(first, last);
      first = last + 1;
    end
    if (cur_test != 0) begin
      finish_test(cur_test);
    end

    open_test();
    run_random();
    finish_test(6);

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog, sized from the number of requests once the vectors are in
  initial begin
    wait (rst_n === 1'b1);
    #(Period * 8 * (nvec + NumRand) + Margin);
    $display("Timeout: the run did not finish within the time allowed for its requests");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== logic/tcdm_group.sv ====
// --------------------
// Local memory group: request crossbar, interleaved
// banks and response crossbar
// --------------------
module tcdm_group (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Requests
  input  logic                 [tcdm_pkg::NumPorts-1:0] req_valid_i,
  input  logic                 [tcdm_pkg::NumPorts-1:0] req_wen_i,
  input  tcdm_pkg::tcdm_addr_u [tcdm_pkg::NumPorts-1:0] req_addr_i,
  input  tcdm_pkg::strb_t      [tcdm_pkg::NumPorts-1:0] req_be_i,
  input  tcdm_pkg::data_t      [tcdm_pkg::NumPorts-1:0] req_wdata_i,
  output logic                 [tcdm_pkg::NumPorts-1:0] req_ready_o,
  // Responses
  output logic                 [tcdm_pkg::NumPorts-1:0] resp_valid_o,
  output tcdm_pkg::data_t      [tcdm_pkg::NumPorts-1:0] resp_rdata_o
);

  import tcdm_pkg::*;

  // --------------------
  // Crossbar to banks
  // --------------------
  logic      [NumBanks-1:0] bank_req;
  logic      [NumBanks-1:0] bank_wen;
  row_t      [NumBanks-1:0] bank_row;
  strb_t     [NumBanks-1:0] bank_be;
  data_t     [NumBanks-1:0] bank_wdata;
  port_idx_t [NumBanks-1:0] bank_ini;

  // Banks to crossbar
  logic      [NumBanks-1:0] bank_rvalid;
  data_t     [NumBanks-1:0] bank_rdata;
  port_idx_t [NumBanks-1:0] bank_rini;

  tcdm_req_xbar i_req_xbar (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_valid_i (req_valid_i),
    .req_wen_i   (req_wen_i  ),
    .req_addr_i  (req_addr_i ),
    .req_be_i    (req_be_i   ),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .bank_req_o  (bank_req   ),
    .bank_wen_o  (bank_wen   ),
    .bank_row_o  (bank_row   ),
    .bank_be_o   (bank_be    ),
    .bank_wdata_o(bank_wdata ),
    .bank_ini_o  (bank_ini   )
  );

  // --------------------
  // Bank array
  // --------------------
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i   (clk_i         ),
      .rst_n_i (rst_n_i       ),
      .req_i   (bank_req[b]   ),
      .wen_i   (bank_wen[b]   ),
      .row_i   (bank_row[b]   ),
      .be_i    (bank_be[b]    ),
      .wdata_i (bank_wdata[b] ),
      .ini_i   (bank_ini[b]   ),
      .rvalid_o(bank_rvalid[b]),
      .rdata_o (bank_rdata[b] ),
      .rini_o  (bank_rini[b]  )
    );
  end

  // Read data back to its port
  tcdm_resp_xbar i_resp_xbar (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .bank_rvalid_i(bank_rvalid ),
    .bank_rdata_i (bank_rdata  ),
    .bank_rini_i  (bank_rini   ),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

// ==== logic/tcdm_resp_xbar.sv ====
// --------------------
// Response crossbar, bank read data back to the tagged port
// --------------------
module tcdm_resp_xbar (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  // Bank side
  input  logic                [tcdm_pkg::NumBanks-1:0]   bank_rvalid_i,
  input  tcdm_pkg::data_t     [tcdm_pkg::NumBanks-1:0]   bank_rdata_i,
  input  tcdm_pkg::port_idx_t [tcdm_pkg::NumBanks-1:0]   bank_rini_i,
  // Port side
  output logic                [tcdm_pkg::NumPorts-1:0]   resp_valid_o,
  output tcdm_pkg::data_t     [tcdm_pkg::NumPorts-1:0]   resp_rdata_o
);

  import tcdm_pkg::*;

  logic [NumPorts-1:0][NumBanks-1:0] hit;

  // Which bank answers which port
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int b = 0; b < NumBanks; b++) begin
        hit[p][b] = bank_rvalid_i[b] && (bank_rini_i[b] == port_idx_t'(p));
      end
    end
  end

  // OR-merge, at most one hit per port
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      resp_valid_o[p] = |hit[p];
      resp_rdata_o[p] = '0;
      for (int b = 0; b < NumBanks; b++) begin
        if (hit[p][b]) begin
          resp_rdata_o[p] = resp_rdata_o[p] | bank_rdata_i[b];
        end
      end
    end
  end

  // One grant per port a cycle earlier keeps responses apart
  for (genvar p = 0; p < NumPorts; p++) begin : gen_chk
    a_single_resp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(hit[p]));
  end

endmodule

// ==== logic/tcdm_bank.sv ====
// --------------------
// Single-port SRAM bank with byte enables
// and a registered read response
// --------------------
module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request, wen high is a write
  input  logic                req_i,
  input  logic                wen_i,
  input  tcdm_pkg::row_t      row_i,
  input  tcdm_pkg::strb_t     be_i,
  input  tcdm_pkg::data_t     wdata_i,
  input  tcdm_pkg::port_idx_t ini_i,
  // Read response
  output logic                rvalid_o,
  output tcdm_pkg::data_t     rdata_o,
  output tcdm_pkg::port_idx_t rini_o
);

  import tcdm_pkg::*;

  data_t     mem [RowsPerBank];
  logic      rvalid_q;
  data_t     rdata_q;
  port_idx_t rini_q;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (be_i[i]) begin
          mem[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Read strobe, one cycle only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i && !wen_i;
    end
  end

  // Data and tag of the read
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      rdata_q <= mem[row_i];
      rini_q  <= ini_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rini_o   = rini_q;

endmodule

// ==== logic/tcdm_req_xbar.sv ====
// --------------------
// Request crossbar: bank decode, per-bank arbitration
// and forwarding of the granted request with its tag
// --------------------
module tcdm_req_xbar (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  // Port side
  input  logic                  [tcdm_pkg::NumPorts-1:0]      req_valid_i,
  input  logic                  [tcdm_pkg::NumPorts-1:0]      req_wen_i,
  input  tcdm_pkg::tcdm_addr_u  [tcdm_pkg::NumPorts-1:0]      req_addr_i,
  input  tcdm_pkg::strb_t       [tcdm_pkg::NumPorts-1:0]      req_be_i,
  input  tcdm_pkg::data_t       [tcdm_pkg::NumPorts-1:0]      req_wdata_i,
  output logic                  [tcdm_pkg::NumPorts-1:0]      req_ready_o,
  // Bank side
  output logic                  [tcdm_pkg::NumBanks-1:0]      bank_req_o,
  output logic                  [tcdm_pkg::NumBanks-1:0]      bank_wen_o,
  output tcdm_pkg::row_t        [tcdm_pkg::NumBanks-1:0]      bank_row_o,
  output tcdm_pkg::strb_t       [tcdm_pkg::NumBanks-1:0]      bank_be_o,
  output tcdm_pkg::data_t       [tcdm_pkg::NumBanks-1:0]      bank_wdata_o,
  output tcdm_pkg::port_idx_t   [tcdm_pkg::NumBanks-1:0]      bank_ini_o
);

  import tcdm_pkg::*;

  logic [NumBanks-1:0][NumPorts-1:0] bank_reqs;
  logic [NumBanks-1:0][NumPorts-1:0] bank_gnt;
  logic [NumPorts-1:0][NumBanks-1:0] port_gnt;

  // --------------------
  // Bank decode
  // --------------------
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        bank_reqs[b][p] = req_valid_i[p] &&
                          (req_addr_i[p].split.bank == bank_idx_t'(b));
        port_gnt[p][b]  = bank_gnt[b][p];
      end
    end
  end

  // One arbiter per bank
  for (genvar b = 0; b < NumBanks; b++) begin : gen_arb
    tcdm_rr_arbiter i_arb (
      .clk_i  (clk_i       ),
      .rst_n_i(rst_n_i     ),
      .req_i  (bank_reqs[b]),
      .gnt_o  (bank_gnt[b] )
    );
  end

  // Ready means this port holds its bank's grant
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      req_ready_o[p] = |port_gnt[p];
    end
  end

  // --------------------
  // Forward granted fields
  // --------------------
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      bank_req_o[b]   = |bank_gnt[b];
      bank_wen_o[b]   = 1'b0;
      bank_row_o[b]   = '0;
      bank_be_o[b]    = '0;
      bank_wdata_o[b] = '0;
      bank_ini_o[b]   = '0;
      for (int p = 0; p < NumPorts; p++) begin
        if (bank_gnt[b][p]) begin
          bank_wen_o[b]   = req_wen_i[p];
          bank_row_o[b]   = req_addr_i[p].split.row;
          bank_be_o[b]    = req_be_i[p];
          bank_wdata_o[b] = req_wdata_i[p];
          bank_ini_o[b]   = port_idx_t'(p);
        end
      end
    end
  end

  // A port addresses one bank, so two banks never grant it together
  for (genvar p = 0; p < NumPorts; p++) begin : gen_chk
    a_port_single_gnt : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(port_gnt[p]));
  end

endmodule

// ==== logic/tcdm_rr_arbiter.sv ====
// --------------------
// Round-robin arbiter, one requesting port per bank
// --------------------
module tcdm_rr_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [tcdm_pkg::NumPorts-1:0] req_i,
  output logic [tcdm_pkg::NumPorts-1:0] gnt_o
);

  import tcdm_pkg::*;

  port_idx_t ptr_q;
  port_idx_t win;
  logic      found;

  // First request at or after the pointer wins
  always_comb begin
    port_idx_t cand;
    gnt_o = '0;
    win   = ptr_q;
    found = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      cand = ptr_q + port_idx_t'(i);
      if (!found && req_i[cand]) begin
        gnt_o[cand] = 1'b1;
        win         = cand;
        found       = 1'b1;
      end
    end
  end

  // Pointer moves just past the winner
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= win + port_idx_t'(1);
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

  a_gnt_has_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_o & ~req_i) == '0);

endmodule

// ==== logic/tcdm_pkg.sv ====
// --------------------
// Sizes and address types shared by the
// local memory group
// --------------------
package tcdm_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int unsigned NumPorts    = 4;
  localparam int unsigned NumBanks    = 4;
  localparam int unsigned RowsPerBank = 16;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;

  // Index widths
  localparam int unsigned BankIdxWidth = $clog2(NumBanks);
  localparam int unsigned RowWidth     = $clog2(RowsPerBank);
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam int unsigned AddrWidth    = BankIdxWidth + RowWidth;

  // --------------------
  // Types
  // --------------------
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [BankIdxWidth-1:0] bank_idx_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // Word address, seen flat or split into row and bank
  // Bank in the low bits interleaves consecutive words across banks
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    struct packed {
      row_t      row;
      bank_idx_t bank;
    } split;
  } tcdm_addr_u;

endpackage
